// File: mpeg_sys_pkg.sv
package mpeg_sys_pkg;

   // stream ids that follow the 00 00 01 prefix
   localparam logic [7:0] SC_PACK      = 8'hBA;
   localparam logic [7:0] SC_SYS_HDR   = 8'hBB;
   localparam logic [7:0] SC_END       = 8'hB9;
   localparam logic [7:0] SID_PRIVATE2 = 8'hBF;  // carries no timestamp field

   // packet header markers
   localparam logic [7:0] STUFF_BYTE = 8'hFF;
   localparam logic [1:0] STD_MARK   = 2'b01;    // top bits of the STD buffer field

   // pack header body after the start code
   localparam int PACK_BODY_LEN = 8;

   // timestamps of one packet, 90 kHz units
   typedef struct packed {
      logic        has_pts;
      logic        has_dts;
      logic [32:0] pts;
      logic [32:0] dts;
   } ts_t;

   // single write bus from the parser to all lanes
   typedef struct packed {
      logic [7:0] lane;
      logic [7:0] data;
   } lane_wr_t;

   // drained payload byte, tagged with its lane
   typedef struct packed {
      logic [7:0] lane;
      logic [7:0] data;
   } out_byte_t;

endpackage

// File: start_code_detect.sv
`timescale 1ns/1ps

module start_code_detect (
   input  logic       read_signal,
   input  logic       rst_n,
   input  logic       arm,
   input  logic       in_valid,
   input  logic [7:0] in_byte,
   output logic       found
);

   logic [1:0] zeros;  // zero bytes seen so far, stops at 2

   always_ff @(posedge read_signal)
   begin
      if (!rst_n)
      begin
         zeros <= 2'd0;
         found <= 1'b0;
      end
      else if (!arm)
      begin
         zeros <= 2'd0;   // parser busy with a packet
         found <= 1'b0;
      end
      else
      begin
         found <= 1'b0;
         if (in_valid)
         begin
            if (in_byte == 8'h00)
               zeros <= (zeros == 2'd2) ? 2'd2 : zeros + 2'd1;  // 00 00 00 01 still matches
            else if (in_byte == 8'h01 && zeros == 2'd2)
            begin
               zeros <= 2'd0;
               found <= 1'b1;
            end
            else
               zeros <= 2'd0;
         end
      end
   end

   // the parser holds arm until it has taken the id byte
   assert property (@(posedge read_signal) disable iff (!rst_n) found |-> arm)
      else $error("start code reported while detector disarmed");

endmodule

// File: pts_dts_parse.sv
`timescale 1ns/1ps

module pts_dts_parse (
   input  logic              read_signal,
   input  logic              rst_n,
   input  logic              start,
   input  logic              in_valid,
   input  logic [7:0]        in_byte,
   output logic              ts_done,
   output logic [3:0]        ts_bytes,
   output mpeg_sys_pkg::ts_t ts
);

   logic        busy;
   logic [2:0]  pos;        // byte within the current 5-byte group
   logic        dts_phase;  // second group of the 10-byte form
   logic [32:0] sh;         // value being assembled
   logic [32:0] field;
   logic        take_first;
   logic        take_next;

   assign take_first = start && in_valid && !busy;
   assign take_next  = busy && in_valid;
   assign field      = {sh[25:0], in_byte[7:1]};  // last 7 bits, marker dropped

   always_ff @(posedge read_signal)
   begin
      if (!rst_n)
      begin
         busy      <= 1'b0;
         pos       <= 3'd0;
         dts_phase <= 1'b0;
         ts_done   <= 1'b0;
      end
      else
      begin
         ts_done <= 1'b0;
         if (take_first)
         begin
            if (in_byte[7:5] == 3'b001)
            begin
               busy      <= 1'b1;
               pos       <= 3'd1;
               dts_phase <= 1'b0;
            end
            else
               ts_done <= 1'b1;   // 0x0F, single byte
         end
         else if (take_next)
         begin
            if (pos == 3'd4)
            begin
               pos <= 3'd0;
               if (dts_phase || !ts.has_dts)
               begin
                  busy    <= 1'b0;
                  ts_done <= 1'b1;
               end
               else
                  dts_phase <= 1'b1;
            end
            else
               pos <= pos + 3'd1;
         end
      end
   end

   always_ff @(posedge read_signal)
   begin
      if (take_first)
      begin
         ts.has_pts <= (in_byte[7:5] == 3'b001);
         ts.has_dts <= (in_byte[7:4] == 4'b0011);
         sh         <= {30'd0, in_byte[3:1]};  // bits 32..30
         ts_bytes   <= 4'd1;
      end
      else if (take_next)
      begin
         case (pos)
            3'd0:       sh <= {30'd0, in_byte[3:1]};   // dts lead byte
            3'd1, 3'd3: sh <= {sh[24:0], in_byte};
            3'd2:       sh <= {sh[25:0], in_byte[7:1]};
            default:
            begin
               if (dts_phase)
                  ts.dts <= field;
               else
                  ts.pts <= field;
               ts_bytes <= dts_phase ? 4'd10 : 4'd5;
            end
         endcase
      end
   end

   // parser must wait for ts_done before the next packet header
   assert property (@(posedge read_signal) disable iff (!rst_n) start |-> !busy)
      else $error("timestamp start during a parse");

endmodule

// File: packet_parser.sv
`timescale 1ns/1ps

module packet_parser #(
   parameter int NUM_LANES = 4
) (
   input  logic                   read_signal,
   input  logic                   rst_n,
   input  logic                   in_valid,
   input  logic [7:0]             in_byte,
   output logic                   wr_en,
   output mpeg_sys_pkg::lane_wr_t wr,
   output logic                   ts_valid,
   output mpeg_sys_pkg::ts_t      ts,
   output logic                   pack_seen,
   output logic                   stream_done
);
   import mpeg_sys_pkg::*;

   typedef enum logic [3:0] {
      S_HUNT, S_ID, S_SKIP, S_SYS_HI, S_SYS_LO, S_LEN_HI, S_LEN_LO,
      S_HDR, S_STD, S_TS, S_PAY
   } state_t;

   state_t      state;
   logic [15:0] remain;     // bytes left in the packet or skip
   logic [15:0] len;
   logic [15:0] rem_after;  // remain once the timestamp field is counted
   logic [7:0]  stream_id;
   logic        arm;
   logic        found;
   logic        ts_start;
   logic        ts_done;
   logic [3:0]  ts_bytes;
   logic        ts_end;
   logic        id_take;
   logic        hdr_stuff;
   logic        hdr_std;

   assign len       = {remain[15:8], in_byte};  // high byte parked in remain
   assign rem_after = remain - 16'(ts_bytes);
   assign ts_end    = (state == S_TS) && ts_done;
   assign id_take   = in_valid && (((state == S_HUNT) && found) || (state == S_ID));
   assign hdr_stuff = (state == S_HDR) && in_valid && (in_byte == STUFF_BYTE);
   assign hdr_std   = (state == S_HDR) && in_valid && (in_byte[7:6] == STD_MARK);
   assign ts_start  = (state == S_HDR) && in_valid && !hdr_stuff && !hdr_std;

   // rearm on the same cycle a packet ends in its timestamp field
   assign arm = (state == S_HUNT) || (ts_end && rem_after == 16'd0);

   assign wr_en    = in_valid && ((state == S_PAY) || (ts_end && rem_after != 16'd0));
   assign wr.lane  = stream_id & 8'(NUM_LANES - 1);
   assign wr.data  = in_byte;
   assign ts_valid = ts_end && ts.has_pts;

   always_ff @(posedge read_signal)
   begin
      if (!rst_n)
      begin
         state       <= S_HUNT;
         remain      <= 16'd0;
         stream_id   <= 8'd0;
         pack_seen   <= 1'b0;
         stream_done <= 1'b0;
      end
      else
      begin
         pack_seen <= 1'b0;
         case (state)
            S_HUNT, S_ID:
               if (id_take)
               begin
                  if (in_byte == SC_PACK)
                  begin
                     remain    <= 16'(PACK_BODY_LEN);
                     pack_seen <= 1'b1;
                     state     <= S_SKIP;
                  end
                  else if (in_byte == SC_END)
                  begin
                     stream_done <= 1'b1;
                     state       <= S_HUNT;
                  end
                  else if (in_byte == SC_SYS_HDR)
                     state <= S_SYS_HI;
                  else
                  begin
                     stream_id <= in_byte;
                     state     <= S_LEN_HI;
                  end
               end
               else if (found)
                  state <= S_ID;   // id byte comes after a gap
            S_SYS_HI, S_LEN_HI:
               if (in_valid)
               begin
                  remain[15:8] <= in_byte;
                  state        <= (state == S_SYS_HI) ? S_SYS_LO : S_LEN_LO;
               end
            S_SYS_LO:
               if (in_valid)
               begin
                  remain <= len;
                  state  <= (len == 16'd0) ? S_HUNT : S_SKIP;
               end
            S_LEN_LO:
               if (in_valid)
               begin
                  remain <= len;
                  if (len == 16'd0)
                     state <= S_HUNT;
                  else if (stream_id == SID_PRIVATE2)
                     state <= S_PAY;
                  else
                     state <= S_HDR;
               end
            S_HDR:
               if (hdr_stuff || hdr_std)
               begin
                  remain <= remain - 16'd1;
                  if (remain == 16'd1)
                     state <= S_HUNT;
                  else if (hdr_std)
                     state <= S_STD;
               end
               else if (ts_start)
                  state <= S_TS;   // this byte is counted through ts_bytes
            S_STD:
               if (in_valid)
               begin
                  remain <= remain - 16'd1;
                  state  <= (remain == 16'd1) ? S_HUNT : S_HDR;
               end
            S_TS:
               if (ts_done)
               begin
                  if (rem_after == 16'd0)
                     state <= S_HUNT;
                  else if (in_valid)
                  begin
                     remain <= rem_after - 16'd1;   // first payload byte already written
                     state  <= (rem_after == 16'd1) ? S_HUNT : S_PAY;
                  end
                  else
                  begin
                     remain <= rem_after;
                     state  <= S_PAY;
                  end
               end
            default:   // S_SKIP, S_PAY
               if (in_valid)
               begin
                  remain <= remain - 16'd1;
                  if (remain == 16'd1)
                     state <= S_HUNT;
               end
         endcase
      end
   end

   start_code_detect u_detect (
      .read_signal (read_signal),
      .rst_n       (rst_n),
      .arm         (arm),
      .in_valid    (in_valid),
      .in_byte     (in_byte),
      .found       (found)
   );

   pts_dts_parse u_ts (
      .read_signal (read_signal),
      .rst_n       (rst_n),
      .start       (ts_start),
      .in_valid    (in_valid),
      .in_byte     (in_byte),
      .ts_done     (ts_done),
      .ts_bytes    (ts_bytes),
      .ts          (ts)
   );

   // the timestamp field has to fit in what the packet length left
   assert property (@(posedge read_signal) disable iff (!rst_n)
      ts_end |-> (remain >= 16'(ts_bytes)))
      else $error("packet length underflow in timestamp field");

endmodule

// File: stream_lane.sv
`timescale 1ns/1ps

module stream_lane #(
   parameter int LANE_ID    = 0,
   parameter int LANE_DEPTH = 16
) (
   input  logic                   read_signal,
   input  logic                   rst_n,
   input  logic                   wr_en,
   input  mpeg_sys_pkg::lane_wr_t wr,
   input  logic                   rd,
   output logic                   empty,
   output logic [7:0]             head,
   output logic                   overflow
);

   localparam int AW = (LANE_DEPTH > 1) ? $clog2(LANE_DEPTH) : 1;

   logic [7:0]  mem [LANE_DEPTH];
   logic [AW-1:0] wptr;
   logic [AW-1:0] rptr;
   logic [AW:0]   count;
   logic          hit;
   logic          full;
   logic          push;

   assign hit   = wr_en && (wr.lane == 8'(LANE_ID));
   assign full  = (count == (AW+1)'(LANE_DEPTH));
   assign push  = hit && !full;
   assign empty = (count == '0);
   assign head  = mem[rptr];

   always_ff @(posedge read_signal)
   begin
      if (!rst_n)
      begin
         wptr     <= '0;
         rptr     <= '0;
         count    <= '0;
         overflow <= 1'b0;
      end
      else
      begin
         if (hit && full)
            overflow <= 1'b1;   // sticky, byte lost
         if (push)
            wptr <= (wptr == AW'(LANE_DEPTH - 1)) ? '0 : wptr + 1'b1;
         if (rd)
            rptr <= (rptr == AW'(LANE_DEPTH - 1)) ? '0 : rptr + 1'b1;
         case ({push, rd})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   always_ff @(posedge read_signal)
   begin
      if (push)
         mem[wptr] <= wr.data;
   end

   // drain only pops lanes it saw as non-empty
   assert property (@(posedge read_signal) disable iff (!rst_n) rd |-> !empty)
      else $error("lane %0d read while empty", LANE_ID);

endmodule

// File: lane_drain.sv
`timescale 1ns/1ps

module lane_drain #(
   parameter int NUM_LANES = 4
) (
   input  logic                    read_signal,
   input  logic                    rst_n,
   input  logic [NUM_LANES-1:0]    empty,
   input  logic [NUM_LANES*8-1:0]  head,
   output logic [NUM_LANES-1:0]    rd,
   output logic                    out_valid,
   output mpeg_sys_pkg::out_byte_t out_byte
);

   localparam int LW = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;

   logic [LW-1:0] ptr;   // first lane to look at
   logic [LW-1:0] pick;
   logic          any;

   always_comb
   begin
      int idx;
      any  = 1'b0;
      pick = ptr;
      for (int i = 0; i < NUM_LANES; i++)
      begin
         idx = (int'(ptr) + i) % NUM_LANES;
         if (!any && !empty[idx])
         begin
            any  = 1'b1;
            pick = LW'(idx);
         end
      end
      rd = '0;
      if (any)
         rd[pick] = 1'b1;
   end

   always_ff @(posedge read_signal)
   begin
      if (!rst_n)
      begin
         ptr       <= '0;
         out_valid <= 1'b0;
      end
      else
      begin
         out_valid <= any;
         if (any)
            ptr <= LW'((int'(pick) + 1) % NUM_LANES);  // rotate past the served lane
      end
   end

   always_ff @(posedge read_signal)
   begin
      if (any)
      begin
         out_byte.lane <= 8'(pick);
         out_byte.data <= head[pick*8 +: 8];
      end
   end

endmodule

// File: mpeg_demux_top.sv
`timescale 1ns/1ps

module mpeg_demux_top #(
   parameter int NUM_LANES  = 4,
   parameter int LANE_DEPTH = 16
) (
   input  logic                    read_signal,
   input  logic                    rst_n,
   input  logic                    in_valid,
   input  logic [7:0]              in_byte,
   output logic                    out_valid,
   output mpeg_sys_pkg::out_byte_t out_byte,
   output logic                    ts_valid,
   output mpeg_sys_pkg::ts_t       ts,
   output logic                    pack_seen,
   output logic                    stream_done,
   output logic [NUM_LANES-1:0]    overflow
);
   import mpeg_sys_pkg::*;

   logic                   wr_en;
   lane_wr_t               wr;
   logic [NUM_LANES-1:0]   empty;
   logic [NUM_LANES-1:0]   rd;
   logic [NUM_LANES*8-1:0] head;   // lane heads, lane 0 in the low byte

   packet_parser #(.NUM_LANES(NUM_LANES)) u_parser (
      .read_signal (read_signal),
      .rst_n       (rst_n),
      .in_valid    (in_valid),
      .in_byte     (in_byte),
      .wr_en       (wr_en),
      .wr          (wr),
      .ts_valid    (ts_valid),
      .ts          (ts),
      .pack_seen   (pack_seen),
      .stream_done (stream_done)
   );

   for (genvar i = 0; i < NUM_LANES; i++)
   begin : g_lane
      stream_lane #(.LANE_ID(i), .LANE_DEPTH(LANE_DEPTH)) u_lane (
         .read_signal (read_signal),
         .rst_n       (rst_n),
         .wr_en       (wr_en),
         .wr          (wr),
         .rd          (rd[i]),
         .empty       (empty[i]),
         .head        (head[i*8 +: 8]),
         .overflow    (overflow[i])
      );
   end

   lane_drain #(.NUM_LANES(NUM_LANES)) u_drain (
      .read_signal (read_signal),
      .rst_n       (rst_n),
      .empty       (empty),
      .head        (head),
      .rd          (rd),
      .out_valid   (out_valid),
      .out_byte    (out_byte)
   );

endmodule

// File: tb_mpeg_demux.sv
`timescale 1ns/1ps

module tb_mpeg_demux;
   import mpeg_sys_pkg::*;

   localparam int NUM_LANES  = 4;
   localparam int LANE_DEPTH = 16;
   localparam int LW         = $clog2(NUM_LANES);
   localparam int NUM_PKTS   = 40;

   logic                 read_signal = 1'b0;
   logic                 rst_n;
   logic                 in_valid;
   logic [7:0]           in_byte;
   logic                 out_valid;
   out_byte_t            out_byte;
   logic                 ts_valid;
   ts_t                  ts;
   logic                 pack_seen;
   logic                 stream_done;
   logic [NUM_LANES-1:0] overflow;

   int         seed = 32'h40662697;
   logic [7:0] stream_q [$];
   logic [7:0] pkt_q [$];               // packet bytes after the length field
   out_byte_t  exp_lane [NUM_LANES][$];
   ts_t        exp_ts [$];
   int         exp_packs;
   logic       exp_done;
   int         pending = 0;             // payload bytes still owed by the DUT
   int         packs = 0;
   int         cycles = 0;
   int         limit = 0;
   logic       end_sent = 1'b0;

   always #5 read_signal = ~read_signal;

   mpeg_demux_top #(.NUM_LANES(NUM_LANES), .LANE_DEPTH(LANE_DEPTH)) i_dut (
      .read_signal (read_signal),
      .rst_n       (rst_n),
      .in_valid    (in_valid),
      .in_byte     (in_byte),
      .out_valid   (out_valid),
      .out_byte    (out_byte),
      .ts_valid    (ts_valid),
      .ts          (ts),
      .pack_seen   (pack_seen),
      .stream_done (stream_done),
      .overflow    (overflow)
   );

   task automatic fail_now(input string msg);
      $display("Fail at %0t ns: %s", $time, msg);
      $display("FAIL: see errors above");
      $fatal(1, "stopped at first error");
   endtask

   task automatic check_out(input out_byte_t got, input out_byte_t exp);
      if (got !== exp)
         fail_now($sformatf("lane %0d byte %02h, expected lane %0d byte %02h",
                            got.lane, got.data, exp.lane, exp.data));
   endtask

   task automatic check_ts(input ts_t got, input ts_t exp);
      // dts only means something with has_dts
      if (got.has_pts !== exp.has_pts || got.has_dts !== exp.has_dts ||
          got.pts !== exp.pts || (exp.has_dts && got.dts !== exp.dts))
         fail_now($sformatf("timestamp %h, expected %h", got, exp));
   endtask

   task automatic check_bit(input logic got, input logic exp, input string what);
      if (got !== exp)
         fail_now($sformatf("%s is %b, expected %b", what, got, exp));
   endtask

   task automatic push_code(input logic [7:0] id);
      stream_q.push_back(8'h00);
      stream_q.push_back(8'h00);
      stream_q.push_back(8'h01);
      stream_q.push_back(id);
   endtask

   // one 33-bit value in its 5-byte marker form
   task automatic put_ts_group(input logic [3:0] pfx, input logic [32:0] v);
      pkt_q.push_back({pfx, v[32:30], 1'b1});
      pkt_q.push_back(v[29:22]);
      pkt_q.push_back({v[21:15], 1'b1});
      pkt_q.push_back(v[14:7]);
      pkt_q.push_back({v[6:0], 1'b1});
   endtask

   task automatic add_pack();
      push_code(SC_PACK);
      repeat (8)
         stream_q.push_back(8'($random(seed)));   // scr and mux rate bytes
   endtask

   task automatic add_sys_hdr();
      int len;
      len = 6 + {$random(seed)} % 6;
      push_code(SC_SYS_HDR);
      stream_q.push_back(8'(len >> 8));
      stream_q.push_back(8'(len));
      repeat (len)
         stream_q.push_back(8'($random(seed)));
   endtask

   function automatic logic [7:0] pick_id();
      case ({$random(seed)} % 8)
         0:       pick_id = 8'hC0;
         1:       pick_id = 8'hC1;
         2:       pick_id = 8'hC2;
         3:       pick_id = 8'hC3;
         4:       pick_id = 8'hE0;
         5:       pick_id = 8'hE5;
         6:       pick_id = 8'hBD;
         default: pick_id = SID_PRIVATE2;
      endcase
   endfunction

   task automatic add_packet(input logic [7:0] id);
      int          pay;
      int          form;
      logic [32:0] pts;
      logic [32:0] dts;
      pkt_q.delete();
      if (id != SID_PRIVATE2)
      begin
         repeat ({$random(seed)} % 4)
            pkt_q.push_back(8'hFF);
         if ($random(seed) & 1)
         begin
            pkt_q.push_back({2'b01, 6'($random(seed))});   // std buffer field
            pkt_q.push_back(8'($random(seed)));
         end
         form = {$random(seed)} % 3;
         pts  = 33'({$random(seed), $random(seed)});
         dts  = 33'({$random(seed), $random(seed)});
         if (form == 0)
            pkt_q.push_back(8'h0F);
         else if (form == 1)
            put_ts_group(4'b0010, pts);
         else
         begin
            put_ts_group(4'b0011, pts);
            put_ts_group(4'b0001, dts);
         end
      end
      pay = 1 + {$random(seed)} % 12;
      if (pay >= 4 && {$random(seed)} % 3 == 0)
      begin
         // start code look-alike inside the payload
         pkt_q.push_back(8'h00);
         pkt_q.push_back(8'h00);
         pkt_q.push_back(8'h01);
         pkt_q.push_back(($random(seed) & 1) ? SC_END : SC_PACK);
         pay -= 4;
      end
      repeat (pay)
         pkt_q.push_back(8'($random(seed)));
      push_code(id);
      stream_q.push_back(8'(pkt_q.size() >> 8));
      stream_q.push_back(8'(pkt_q.size()));
      foreach (pkt_q[k])
         stream_q.push_back(pkt_q[k]);
   endtask

   task automatic build_stream();
      add_pack();
      add_sys_hdr();
      for (int p = 0; p < NUM_PKTS; p++)
      begin
         if (p % 8 == 7)
            add_pack();
         add_packet((p == 1) ? SID_PRIVATE2 : pick_id());
      end
      push_code(SC_END);
   endtask

   function automatic logic [32:0] ts_field(input int p);
      return {stream_q[p][3:1], stream_q[p + 1], stream_q[p + 2][7:1],
              stream_q[p + 3], stream_q[p + 4][7:1]};
   endfunction

   // walks the built stream the way a demux should
   function automatic void predict();
      int         i;
      int         zeros;
      int         n;
      logic [7:0] id;
      ts_t        t;
      out_byte_t  e;
      i         = 0;
      zeros     = 0;
      exp_packs = 0;
      exp_done  = 1'b0;
      while (i < stream_q.size())
      begin
         if (stream_q[i] == 8'h01 && zeros >= 2)
         begin
            id    = stream_q[i + 1];
            i     = i + 2;
            zeros = 0;
            if (id == SC_PACK)
            begin
               exp_packs++;
               i += PACK_BODY_LEN;
            end
            else if (id == SC_END)
               exp_done = 1'b1;
            else if (id == SC_SYS_HDR)
               i += 2 + int'({stream_q[i], stream_q[i + 1]});
            else
            begin
               n = i + 2 + int'({stream_q[i], stream_q[i + 1]});   // packet end
               i += 2;
               if (id != SID_PRIVATE2)
               begin
                  while (stream_q[i] == 8'hFF || stream_q[i][7:6] == 2'b01)
                     i += (stream_q[i] == 8'hFF) ? 1 : 2;
                  t = '0;
                  if (stream_q[i][7:5] == 3'b001)
                  begin
                     t.has_pts = 1'b1;
                     t.has_dts = stream_q[i][4];
                     t.pts     = ts_field(i);
                     if (t.has_dts)
                        t.dts = ts_field(i + 5);
                     exp_ts.push_back(t);
                     i += t.has_dts ? 10 : 5;
                  end
                  else
                     i++;   // 0x0F form without timestamp
               end
               e.lane = 8'(int'(id) % NUM_LANES);
               for (int k = i; k < n; k++)
               begin
                  e.data = stream_q[k];
                  exp_lane[e.lane[LW-1:0]].push_back(e);
                  pending++;
               end
               i = n;
            end
         end
         else
         begin
            zeros = (stream_q[i] == 8'h00) ? zeros + 1 : 0;
            i++;
         end
      end
   endfunction

   // scoreboard sampled mid-cycle
   always @(negedge read_signal)
   begin
      out_byte_t     want;
      logic [LW-1:0] ln;
      if (rst_n)
      begin
         if (out_valid)
         begin
            ln = out_byte.lane[LW-1:0];
            if (out_byte.lane >= 8'(NUM_LANES) || exp_lane[ln].size() == 0)
               fail_now($sformatf("unexpected byte %02h on lane %0d",
                                  out_byte.data, out_byte.lane));
            want = exp_lane[ln].pop_front();
            check_out(out_byte, want);
            pending--;
         end
         if (ts_valid)
         begin
            if (exp_ts.size() == 0)
               fail_now("ts_valid with no timestamp left to expect");
            check_ts(ts, exp_ts.pop_front());
         end
         if (pack_seen)
            packs++;
         if (!end_sent)
            check_bit(stream_done, 1'b0, "stream_done before end code");
         check_bit(|overflow, 1'b0, "overflow");
      end
   end

   always @(posedge read_signal)
   begin
      cycles <= cycles + 1;
      if (limit > 0 && cycles >= limit)
      begin
         $display("timeout after %0d cycles, output never finished", cycles);
         $display("FAIL: see errors above");
         $fatal(1, "timeout");
      end
   end

   initial
   begin
      rst_n    = 1'b0;
      in_valid = 1'b0;
      in_byte  = 8'h00;
      build_stream();
      predict();
      // at most one idle cycle per byte
      limit = 2 * stream_q.size() + LANE_DEPTH * NUM_LANES + 100;
      repeat (2)
         @(posedge read_signal);
      #1;
      rst_n = 1'b1;
      foreach (stream_q[k])
      begin
         if ({$random(seed)} % 4 == 0)
         begin
            in_valid = 1'b0;
            in_byte  = 8'($random(seed));   // junk while idle
            @(posedge read_signal);
            #1;
         end
         in_valid = 1'b1;
         in_byte  = stream_q[k];
         @(posedge read_signal);
         #1;
      end
      in_valid = 1'b0;
      end_sent = 1'b1;
      wait (pending == 0);
      repeat (2 * NUM_LANES)
         @(posedge read_signal);   // room for stray output bytes
      check_bit(stream_done, exp_done, "stream_done at end of stream");
      if (packs == exp_packs && exp_ts.size() == 0)
      begin
         $display("PASS: all tests");
         $finish;
      end
      else
         fail_now($sformatf("%0d pack headers seen, expected %0d, %0d timestamps missing",
                            packs, exp_packs, exp_ts.size()));
   end

endmodule

// File: tb.f
mpeg_sys_pkg.sv
start_code_detect.sv
pts_dts_parse.sv
packet_parser.sv
stream_lane.sv
lane_drain.sv
mpeg_demux_top.sv
tb_mpeg_demux.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the demux testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f tb.f --top-module tb_mpeg_demux -o sim_tb
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

out="$(./obj_dir/sim_tb 2>&1)"
status=$?
echo "$out"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if echo "$out" | grep -qx "PASS: all tests"; then
   exit 0
fi
exit 1
